// ==== hw/engine_config.svh ====
`ifndef ENGINE_CONFIG_SVH
`define ENGINE_CONFIG_SVH

// Number of engine ports merged onto one stream
`define ENGINE_NUM_REQUESTORS 4

// Per-port input FIFO sizing
// Threshold leaves four slots for late requests
`define ENGINE_IN_FIFO_DEPTH 16
`define ENGINE_IN_PROG_THRESH 12

// Shared output FIFO sizing
// Headroom covers the two register stages after the arbiter
`define ENGINE_OUT_FIFO_DEPTH 16
`define ENGINE_OUT_PROG_THRESH 12

// Request field widths
`define ENGINE_VERTEX_WIDTH 32
`define ENGINE_DATA_WIDTH 32

`endif

// ==== hw/graph_engine_pkg.sv ====
`include "engine_config.svh"

package graph_engine_pkg;

  // ------------------------------
  // Source id sizing
  // ------------------------------
  // Wide enough to number every engine port
  localparam int ENGINE_SOURCE_ID_WIDTH =
    (`ENGINE_NUM_REQUESTORS > 1) ? $clog2(`ENGINE_NUM_REQUESTORS) : 1;

  typedef logic [ENGINE_SOURCE_ID_WIDTH-1:0] engine_source_id_t;

  // ------------------------------
  // Request opcodes
  // ------------------------------
  typedef enum logic [1:0] {
    OP_READ_VERTEX     = 2'd0,
    OP_WRITE_VERTEX    = 2'd1,
    OP_READ_EDGE       = 2'd2,
    OP_UPDATE_PROPERTY = 2'd3
  } engine_opcode_e;

  // Request as issued by one engine
  typedef struct packed {
    engine_opcode_e                  opcode;
    logic [`ENGINE_VERTEX_WIDTH-1:0] vertex_id;
    logic [`ENGINE_DATA_WIDTH-1:0]   data;
  } engine_request_t;

  // Merged packet, request stamped with its source port
  typedef struct packed {
    engine_source_id_t source_id;
    engine_request_t   request;
  } engine_packet_t;

endpackage

// ==== hw/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter int DEPTH       = 16,
  parameter int WIDTH       = 32,
  parameter int PROG_THRESH = 12
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic [WIDTH-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty,
  output logic             prog_full
);

  // ------------------------------
  // Sizing
  // ------------------------------
  localparam int ADDR_WIDTH  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  // Last valid slot, pointers wrap after it
  localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(DEPTH - 1);

  // Storage and bookkeeping
  logic [WIDTH-1:0]       mem [DEPTH];
  logic [ADDR_WIDTH-1:0]  wr_ptr;
  logic [ADDR_WIDTH-1:0]  rd_ptr;
  logic [COUNT_WIDTH-1:0] count;

  // Accepted operations this cycle
  logic do_write;
  logic do_read;

  // Pointer advance with wrap for any depth
  function automatic logic [ADDR_WIDTH-1:0] next_ptr(input logic [ADDR_WIDTH-1:0] ptr);
    return (ptr == LAST_ADDR) ? '0 : ptr + 1'b1;
  endfunction

  // ------------------------------
  // Status flags
  // ------------------------------
  // All flags come straight from the fill counter
  assign full      = (count == COUNT_WIDTH'(DEPTH));
  assign empty     = (count == '0);
  assign prog_full = (count >= COUNT_WIDTH'(PROG_THRESH));

  // Overflow and underflow attempts are dropped here
  assign do_write = wr_en & ~full;
  assign do_read  = rd_en & ~empty;

  // Show-ahead, head visible without a pop
  assign dout = mem[rd_ptr];

  // ------------------------------
  // Storage write
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
  end

  // ------------------------------
  // Pointers and fill count
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_read) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      count <= '0;
    end else begin
      // Simultaneous push and pop leaves the count alone
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hw/round_robin_arbiter.sv ====
`timescale 1ns/1ps

module round_robin_arbiter #(
  parameter int NUM_REQUESTORS = 4,
  parameter int WIDTH          = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1
) (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic [NUM_REQUESTORS-1:0]         arbiter_req,
  input  graph_engine_pkg::engine_request_t arbiter_bus_in [NUM_REQUESTORS-1:0],
  output logic [NUM_REQUESTORS-1:0]         arbiter_grant,
  output logic                              arbiter_bus_valid,
  output graph_engine_pkg::engine_packet_t  arbiter_bus_out
);

  import graph_engine_pkg::*;

  // Index of the previous winner
  logic [WIDTH-1:0] last_winner;

  // Index of this cycle's winner
  logic [WIDTH-1:0] winner_idx;

  // Any port granted this cycle
  logic grant_any;

  // ------------------------------
  // Grant selection
  // ------------------------------
  // Search starts one past the last winner and wraps
  always_comb begin
    int   idx;
    logic found;
    found         = 1'b0;
    idx           = 0;
    arbiter_grant = '0;
    winner_idx    = last_winner;
    for (int off = 1; off <= NUM_REQUESTORS; off++) begin
      idx = (int'(last_winner) + off) % NUM_REQUESTORS;
      // First requesting port in cyclic order wins
      if (!found && arbiter_req[idx]) begin
        found              = 1'b1;
        arbiter_grant[idx] = 1'b1;
        winner_idx         = WIDTH'(idx);
      end
    end
  end

  assign grant_any = |arbiter_grant;

  // ------------------------------
  // Priority pointer
  // ------------------------------
  // Starts at the top port so port 0 goes first
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      last_winner <= WIDTH'(NUM_REQUESTORS - 1);
    end else if (grant_any) begin
      last_winner <= winner_idx;
    end
  end

  // ------------------------------
  // Registered winner
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      arbiter_bus_valid <= 1'b0;
    end else begin
      arbiter_bus_valid <= grant_any;
    end
  end

  // Payload only loads on a grant, valid qualifies it
  always_ff @(posedge ap_clk) begin
    if (grant_any) begin
      arbiter_bus_out.request   <= arbiter_bus_in[winner_idx];
      arbiter_bus_out.source_id <= engine_source_id_t'(winner_idx);
    end
  end

endmodule

// ==== hw/request_arbiter_engine.sv ====
`timescale 1ns/1ps
`include "engine_config.svh"

module request_arbiter_engine #(
  parameter int NUM_REQUESTORS = `ENGINE_NUM_REQUESTORS
) (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic [NUM_REQUESTORS-1:0]         request_in_valid,
  input  graph_engine_pkg::engine_request_t request_in_payload [NUM_REQUESTORS-1:0],
  output logic [NUM_REQUESTORS-1:0]         request_in_ready,
  output logic                              request_out_valid,
  output graph_engine_pkg::engine_packet_t  request_out_payload,
  input  logic                              request_out_ready,
  output logic                              fifo_setup
);

  import graph_engine_pkg::*;

  // Flattened widths for the FIFO data paths
  localparam int REQ_WIDTH = $bits(engine_request_t);
  localparam int PKT_WIDTH = $bits(engine_packet_t);
  localparam int ID_WIDTH  = $bits(engine_source_id_t);

  // ------------------------------
  // Internal signals
  // ------------------------------
  // Local reset copies, one per domain of logic
  logic areset_control_reg;
  logic areset_fifo;
  logic areset_arbiter;

  // Registered upstream handshake
  logic [NUM_REQUESTORS-1:0] request_in_reg_valid;
  engine_request_t           request_in_reg_payload [NUM_REQUESTORS-1:0];

  // Per-port input FIFO controls and flags
  logic [NUM_REQUESTORS-1:0] in_fifo_wr_en;
  logic [NUM_REQUESTORS-1:0] in_fifo_rd_en;
  logic [NUM_REQUESTORS-1:0] in_fifo_full;
  logic [NUM_REQUESTORS-1:0] in_fifo_empty;
  logic [NUM_REQUESTORS-1:0] in_fifo_prog_full;
  engine_request_t           in_fifo_dout [NUM_REQUESTORS-1:0];

  // Arbiter interface
  logic [NUM_REQUESTORS-1:0] arbiter_req;
  logic [NUM_REQUESTORS-1:0] arbiter_grant;
  logic                      arbiter_bus_valid;
  engine_packet_t            arbiter_bus_out;

  // Stage between arbiter and output FIFO
  logic           out_din_valid;
  engine_packet_t out_din_payload;

  // Output FIFO controls and flags
  logic out_fifo_rd_en;
  logic out_fifo_full;
  logic out_fifo_empty;
  logic out_fifo_prog_full;

  // Output FIFO too full to take more packets
  logic out_stall;

  // ------------------------------
  // Reset distribution
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    areset_control_reg <= areset_control;
    areset_fifo        <= areset_control;
    areset_arbiter     <= areset_control;
  end

  // ------------------------------
  // Input registers
  // ------------------------------
  // Only handshaked beats are captured
  always_ff @(posedge ap_clk) begin
    if (areset_control_reg) begin
      request_in_reg_valid <= '0;
    end else begin
      request_in_reg_valid <= request_in_valid & request_in_ready;
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      request_in_reg_payload[i] <= request_in_payload[i];
    end
  end

  // ------------------------------
  // Per-port input FIFOs
  // ------------------------------
  for (genvar gi = 0; gi < NUM_REQUESTORS; gi++) begin : gen_in_fifo
    // Push the registered beat, pop on grant
    assign in_fifo_wr_en[gi] = request_in_reg_valid[gi];
    assign in_fifo_rd_en[gi] = arbiter_grant[gi];

    sync_fifo #(
      .DEPTH      (`ENGINE_IN_FIFO_DEPTH),
      .WIDTH      (REQ_WIDTH),
      .PROG_THRESH(`ENGINE_IN_PROG_THRESH)
    ) u_in_fifo (
      .ap_clk        (ap_clk),
      .areset_control(areset_fifo),
      .din           (request_in_reg_payload[gi]),
      .wr_en         (in_fifo_wr_en[gi]),
      .rd_en         (in_fifo_rd_en[gi]),
      .dout          (in_fifo_dout[gi]),
      .full          (in_fifo_full[gi]),
      .empty         (in_fifo_empty[gi]),
      .prog_full     (in_fifo_prog_full[gi])
    );
  end

  // ------------------------------
  // Arbitration
  // ------------------------------
  assign out_stall = out_fifo_prog_full | out_fifo_full;

  // Held off entirely while the output FIFO is at threshold
  assign arbiter_req = ~in_fifo_empty & {NUM_REQUESTORS{~out_stall}};

  round_robin_arbiter #(
    .NUM_REQUESTORS(NUM_REQUESTORS),
    .WIDTH         (ID_WIDTH)
  ) u_arbiter (
    .ap_clk           (ap_clk),
    .areset_control   (areset_arbiter),
    .arbiter_req      (arbiter_req),
    .arbiter_bus_in   (in_fifo_dout),
    .arbiter_grant    (arbiter_grant),
    .arbiter_bus_valid(arbiter_bus_valid),
    .arbiter_bus_out  (arbiter_bus_out)
  );

  // ------------------------------
  // Output FIFO
  // ------------------------------
  // One more register stage before the push
  always_ff @(posedge ap_clk) begin
    if (areset_control_reg) begin
      out_din_valid <= 1'b0;
    end else begin
      out_din_valid <= arbiter_bus_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_din_payload <= arbiter_bus_out;
  end

  // Downstream pops on a valid/ready transfer
  assign request_out_valid = ~out_fifo_empty;
  assign out_fifo_rd_en    = request_out_valid & request_out_ready;

  sync_fifo #(
    .DEPTH      (`ENGINE_OUT_FIFO_DEPTH),
    .WIDTH      (PKT_WIDTH),
    .PROG_THRESH(`ENGINE_OUT_PROG_THRESH)
  ) u_out_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_fifo),
    .din           (out_din_payload),
    .wr_en         (out_din_valid),
    .rd_en         (out_fifo_rd_en),
    .dout          (request_out_payload),
    .full          (out_fifo_full),
    .empty         (out_fifo_empty),
    .prog_full     (out_fifo_prog_full)
  );

  // ------------------------------
  // Setup flag and upstream ready
  // ------------------------------
  // High while the reset registers are active
  always_ff @(posedge ap_clk) begin
    if (areset_control_reg) begin
      fifo_setup <= 1'b1;
    end else begin
      fifo_setup <= 1'b0;
    end
  end

  // Ready follows setup by one cycle
  always_ff @(posedge ap_clk) begin
    if (areset_control_reg) begin
      request_in_ready <= '0;
    end else begin
      for (int i = 0; i < NUM_REQUESTORS; i++) begin
        request_in_ready[i] <= ~fifo_setup & ~in_fifo_prog_full[i] & ~in_fifo_full[i]
                               & ~out_stall;
      end
    end
  end

endmodule

// ==== hw/request_arbiter_top.sv ====
`timescale 1ns/1ps
`include "engine_config.svh"

module request_arbiter_top (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  // ------------------------------
  // Engine side, one lane per port
  // ------------------------------
  input  logic [`ENGINE_NUM_REQUESTORS-1:0] request_in_valid,
  input  graph_engine_pkg::engine_request_t request_in_payload [`ENGINE_NUM_REQUESTORS-1:0],
  output logic [`ENGINE_NUM_REQUESTORS-1:0] request_in_ready,
  // ------------------------------
  // Merged stream to the consumer
  // ------------------------------
  output logic                              request_out_valid,
  output graph_engine_pkg::engine_packet_t  request_out_payload,
  input  logic                              request_out_ready,
  // Reset still settling
  output logic                              fifo_setup
);

  // Port count fixed from the config header
  // FIFO depths and thresholds come from the same header
  request_arbiter_engine #(
    .NUM_REQUESTORS(`ENGINE_NUM_REQUESTORS)
  ) u_engine (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .request_in_valid   (request_in_valid),
    .request_in_payload (request_in_payload),
    .request_in_ready   (request_in_ready),
    .request_out_valid  (request_out_valid),
    .request_out_payload(request_out_payload),
    .request_out_ready  (request_out_ready),
    .fifo_setup         (fifo_setup)
  );

endmodule

// ==== verif/request_arbiter_assertions.sv ====
`timescale 1ns/1ps

module request_arbiter_assertions #(
  parameter int NUM_REQUESTORS = 4
) (
  input logic                             ap_clk,
  input logic                             areset_control,
  input logic                             areset_fifo,
  input logic [NUM_REQUESTORS-1:0]        in_fifo_wr_en,
  input logic [NUM_REQUESTORS-1:0]        in_fifo_full,
  input logic                             request_out_valid,
  input logic                             request_out_ready,
  input graph_engine_pkg::engine_packet_t request_out_payload
);

  // ------------------------------
  // Downstream handshake
  // ------------------------------
  // Stalled head stays put until taken
  assert property (@(posedge ap_clk) disable iff (areset_control)
    request_out_valid && !request_out_ready |=> request_out_valid
                                                && $stable(request_out_payload))
    else $error("Output payload changed while the consumer stalled");

  // FIFO reset empties the output one edge later
  assert property (@(posedge ap_clk) areset_fifo |=> !request_out_valid)
    else $error("Output valid high during reset");

  // ------------------------------
  // Input FIFO overflow
  // ------------------------------
  for (genvar gi = 0; gi < NUM_REQUESTORS; gi++) begin : gen_no_overflow
    assert property (@(posedge ap_clk) disable iff (areset_control)
      in_fifo_wr_en[gi] |-> !in_fifo_full[gi])
      else $error("Input FIFO %0d written while full", gi);
  end

endmodule

bind request_arbiter_engine request_arbiter_assertions #(
  .NUM_REQUESTORS(NUM_REQUESTORS)
) u_assertions (
  .ap_clk             (ap_clk),
  .areset_control     (areset_control),
  .areset_fifo        (areset_fifo),
  .in_fifo_wr_en      (in_fifo_wr_en),
  .in_fifo_full       (in_fifo_full),
  .request_out_valid  (request_out_valid),
  .request_out_ready  (request_out_ready),
  .request_out_payload(request_out_payload)
);

// ==== verif/request_arbiter_tb.sv ====
`timescale 1ns/1ps
`include "engine_config.svh"

module request_arbiter_tb;

  import graph_engine_pkg::*;

  localparam int NUM           = `ENGINE_NUM_REQUESTORS;
  localparam int ORDER_BURST   = 12;
  localparam int RR_PER_PORT   = 8;
  localparam int BP_CYCLES     = 40;
  localparam int RAND_CYCLES   = 400;
  localparam int DRAIN_LIMIT   = 1000;
  // Upper bound on requests issued over all tests
  localparam int TOTAL_REQUESTS = NUM + ORDER_BURST + RR_PER_PORT * NUM
                                  + BP_CYCLES * NUM + RAND_CYCLES * NUM;
  localparam int WATCHDOG_CYCLES = TOTAL_REQUESTS * NUM * 20 + 2000;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic            ap_clk;
  logic            areset_control;
  logic [NUM-1:0]  request_in_valid;
  engine_request_t request_in_payload [NUM-1:0];
  logic [NUM-1:0]  request_in_ready;
  logic            request_out_valid;
  engine_packet_t  request_out_payload;
  logic            request_out_ready;
  logic            fifo_setup;

  // Scoreboard, one expected queue per source port
  engine_request_t exp_q [NUM][$];
  engine_request_t next_req [NUM];
  int              out_order [$];
  int              delivered_count;

  // Bookkeeping
  string       current_test;
  int          error_count;
  int          test_start_errors;
  int          tests_passed;
  int          tests_failed;
  logic [31:0] lcg_state;

  request_arbiter_top uut (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .request_in_valid   (request_in_valid),
    .request_in_payload (request_in_payload),
    .request_in_ready   (request_in_ready),
    .request_out_valid  (request_out_valid),
    .request_out_payload(request_out_payload),
    .request_out_ready  (request_out_ready),
    .fifo_setup         (fifo_setup)
  );

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic engine_request_t make_request(input engine_opcode_e op,
                                                   input logic [31:0] vertex,
                                                   input logic [31:0] data);
    engine_request_t req;
    req.opcode    = op;
    req.vertex_id = vertex;
    req.data      = data;
    return req;
  endfunction

  function automatic int pending_count();
    int total;
    total = 0;
    for (int i = 0; i < NUM; i++) begin
      total += exp_q[i].size();
    end
    return total;
  endfunction

  task automatic check_value(input string what, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("ERR %s %s: expected %0h actual %0h", current_test, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic start_test(input string name);
    current_test      = name;
    test_start_errors = error_count;
  endtask

  task automatic end_test();
    if (error_count == test_start_errors) begin
      tests_passed++;
      $display("%s: ok", current_test);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", current_test, error_count - test_start_errors);
    end
  endtask

  // One beat on the falling edge, valid only where ready is already high
  task automatic drive_beat(input logic [NUM-1:0] want, output logic [NUM-1:0] taken);
    @(negedge ap_clk);
    for (int i = 0; i < NUM; i++) begin
      taken[i]              = want[i] & request_in_ready[i];
      request_in_valid[i]   = taken[i];
      request_in_payload[i] = next_req[i];
      if (taken[i]) begin
        exp_q[i].push_back(next_req[i]);
      end
    end
  endtask

  task automatic release_inputs();
    @(negedge ap_clk);
    request_in_valid = '0;
  endtask

  // Consumer ready must already be high
  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((pending_count() != 0 || request_out_valid) && waited < DRAIN_LIMIT) begin
      @(negedge ap_clk);
      waited++;
    end
    if (pending_count() != 0 || request_out_valid) begin
      $display("Drain timed out in %s with %0d requests still pending",
               current_test, pending_count());
      error_count++;
    end
    // Quiet window so stray outputs get caught
    repeat (10) @(negedge ap_clk);
  endtask

  // ------------------------------
  // Output monitor
  // ------------------------------
  // Sampled on the edge where the transfer happens
  always @(posedge ap_clk) begin
    int              src;
    engine_request_t exp_req;
    if (!areset_control && request_out_valid && request_out_ready) begin
      src = int'(request_out_payload.source_id);
      out_order.push_back(src);
      delivered_count++;
      if (exp_q[src].size() == 0) begin
        $display("Unexpected output from source %0d during %s", src, current_test);
        error_count++;
      end else begin
        exp_req = exp_q[src].pop_front();
        check_value("packet", exp_req, request_out_payload.request);
      end
    end
  end

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic reset_sequence();
    int waited;
    start_test("reset");
    @(negedge ap_clk);
    areset_control = 1'b1;
    for (int c = 0; c < 10; c++) begin
      @(negedge ap_clk);
      // Internal reset copies need two edges to settle
      if (c >= 2) begin
        check_value("out_valid in reset", 1'b0, request_out_valid);
        check_value("ready in reset", '0, request_in_ready);
        check_value("setup in reset", 1'b1, fifo_setup);
      end
    end
    areset_control = 1'b0;
    @(negedge ap_clk);
    check_value("out_valid after reset", 1'b0, request_out_valid);
    check_value("ready after reset", '0, request_in_ready);
    check_value("setup after reset", 1'b1, fifo_setup);
    // Setup drops on the very next edge
    @(negedge ap_clk);
    check_value("setup cleared", 1'b0, fifo_setup);
    waited = 0;
    while (request_in_ready != {NUM{1'b1}} && waited < 3) begin
      @(negedge ap_clk);
      waited++;
    end
    check_value("ready raised", {NUM{1'b1}}, request_in_ready);
    end_test();
  endtask

  task automatic pass_through();
    logic [NUM-1:0] taken;
    start_test("pass_through");
    request_out_ready = 1'b1;
    // Distinct opcode, vertex and data per port
    for (int i = 0; i < NUM; i++) begin
      next_req[i] = make_request(engine_opcode_e'(i % 4), 32'h1000 + 32'(i * 17),
                                 32'hA000_0000 | 32'(i));
    end
    drive_beat({NUM{1'b1}}, taken);
    check_value("all accepted", {NUM{1'b1}}, taken);
    release_inputs();
    wait_drain();
    end_test();
  endtask

  task automatic port_ordering();
    logic [NUM-1:0] taken;
    int             sent;
    int             port;
    start_test("port_ordering");
    request_out_ready = 1'b1;
    port = NUM - 1;
    sent = 0;
    while (sent < ORDER_BURST) begin
      next_req[port] = make_request(OP_WRITE_VERTEX, 32'h200 + 32'(sent), lcg_next());
      drive_beat(NUM'(1) << port, taken);
      if (taken[port]) begin
        sent++;
      end
    end
    release_inputs();
    wait_drain();
    end_test();
  endtask

  task automatic round_robin_fairness();
    logic [NUM-1:0] want;
    logic [NUM-1:0] taken;
    int             sent [NUM];
    start_test("round_robin");
    @(negedge ap_clk);
    request_out_ready = 1'b0;
    out_order.delete();
    for (int i = 0; i < NUM; i++) begin
      sent[i] = 0;
    end
    want = {NUM{1'b1}};
    while (want != '0) begin
      for (int i = 0; i < NUM; i++) begin
        want[i]     = (sent[i] < RR_PER_PORT);
        next_req[i] = make_request(OP_READ_EDGE, 32'((i << 8) | sent[i]), lcg_next());
      end
      drive_beat(want, taken);
      for (int i = 0; i < NUM; i++) begin
        sent[i] += int'(taken[i]);
        want[i]  = (sent[i] < RR_PER_PORT);
      end
    end
    release_inputs();
    // Let the output FIFO fill before opening the consumer
    repeat (20) @(negedge ap_clk);
    request_out_ready = 1'b1;
    wait_drain();
    check_value("output count", RR_PER_PORT * NUM, out_order.size());
    // Every port stays busy, so sources must rotate by one each output
    for (int k = 1; k < out_order.size(); k++) begin
      check_value("source order", (out_order[k-1] + 1) % NUM, out_order[k]);
    end
    end_test();
  endtask

  task automatic back_pressure();
    logic [NUM-1:0] taken;
    int             accepted;
    int             delivered_before;
    start_test("back_pressure");
    @(negedge ap_clk);
    request_out_ready = 1'b0;
    accepted          = 0;
    delivered_before  = delivered_count;
    for (int c = 0; c < BP_CYCLES; c++) begin
      for (int i = 0; i < NUM; i++) begin
        next_req[i] = make_request(OP_UPDATE_PROPERTY, 32'((i << 12) | c), lcg_next());
      end
      drive_beat({NUM{1'b1}}, taken);
      accepted += $countones(taken);
    end
    check_value("ready under stall", '0, request_in_ready);
    release_inputs();
    request_out_ready = 1'b1;
    wait_drain();
    check_value("delivered count", accepted, delivered_count - delivered_before);
    end_test();
  endtask

  task automatic random_traffic();
    logic [NUM-1:0] taken;
    logic [31:0]    rv;
    logic [31:0]    op_bits;
    start_test("random_traffic");
    for (int c = 0; c < RAND_CYCLES; c++) begin
      rv = lcg_next();
      for (int i = 0; i < NUM; i++) begin
        op_bits     = lcg_next();
        next_req[i] = make_request(engine_opcode_e'(op_bits[21:20]), lcg_next(), lcg_next());
      end
      // Upper LCG bits, the low ones cycle too fast
      drive_beat(rv[16 +: NUM], taken);
      request_out_ready = rv[28] | rv[29];
    end
    release_inputs();
    request_out_ready = 1'b1;
    wait_drain();
    check_value("queues empty", 0, pending_count());
    end_test();
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    areset_control    = 1'b1;
    request_in_valid  = '0;
    request_out_ready = 1'b0;
    for (int i = 0; i < NUM; i++) begin
      request_in_payload[i] = '0;
      next_req[i]           = '0;
    end
    lcg_state         = 32'd92855;
    error_count       = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    delivered_count   = 0;
    current_test      = "init";
    reset_sequence();
    pass_through();
    port_ordering();
    round_robin_fairness();
    back_pressure();
    random_traffic();
    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
    $display("Timeout: simulation ran past %0d cycles during %s", WATCHDOG_CYCLES,
             current_test);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+hw
hw/graph_engine_pkg.sv
hw/sync_fifo.sv
hw/round_robin_arbiter.sv
hw/request_arbiter_engine.sv
hw/request_arbiter_top.sv
verif/request_arbiter_assertions.sv
verif/request_arbiter_tb.sv

// ==== Bender.yml ====
package:
  name: request_arbiter

sources:
  # RTL
  - include_dirs:
      - hw
    files:
      - hw/graph_engine_pkg.sv
      - hw/sync_fifo.sv
      - hw/round_robin_arbiter.sv
      - hw/request_arbiter_engine.sv
      - hw/request_arbiter_top.sv
  # Testbench and bound assertions
  - target: test
    include_dirs:
      - hw
    files:
      - verif/request_arbiter_assertions.sv
      - verif/request_arbiter_tb.sv
